//--- common/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// System clock rate in Hz.
`define UART_CLK_FREQ_HZ 1843200

// Line rate in bits per second.
`define UART_BAUD_BPS 115200

// Clock cycles spent on each bit of the frame.
`define UART_CLKS_PER_BIT ((`UART_CLK_FREQ_HZ) / (`UART_BAUD_BPS))

// Width of the counter that measures one bit period.
`define UART_BAUD_CNT_W ($clog2(`UART_CLKS_PER_BIT))

// Default number of bytes the transmit FIFO holds, a power of two.
`define UART_FIFO_DEPTH 8

`endif

//--- common/uart_pkg.sv
`include "uart_consts.svh"

package uart_pkg;

    // One data byte from the host, through the FIFO, into the engine.
    typedef logic [7:0] byte_t;

    // Shift register contents, stop bit at the top and start bit at the bottom.
    typedef logic [9:0] frame_t;

    // Count of frame bits already sent, 0 to 9.
    typedef logic [3:0] bit_idx_t;

    // Position inside the current bit period.
    typedef logic [`UART_BAUD_CNT_W-1:0] baud_cnt_t;

    // Serial engine states.
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LOAD,
        TX_SEND
    } tx_state_e;

endpackage

//--- verilog/tx_fifo.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module tx_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t wr_data,
    input  logic  wr_en,
    output logic  full,
    output byte_t rd_data,
    output logic  rd_avail,
    input  logic  rd_take
);

    localparam int AW = $clog2(DEPTH);

    // Pointers carry one extra wrap bit so that full and empty differ.
    typedef logic [AW:0] ptr_t;

    byte_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;

    logic do_write;
    logic do_read;

    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign rd_avail = (wr_ptr != rd_ptr);

    assign do_write = wr_en && !full;    // A write into a full FIFO is dropped.
    assign do_read  = rd_take && rd_avail;

    // The head byte is shown as soon as it is stored.
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Reads and writes on the same edge touch different pointers, so both take effect.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- serial_send/baud_gen.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module baud_gen
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic tick
);

    localparam baud_cnt_t LAST_CNT = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);

    baud_cnt_t cnt;

    // The count runs freely and wraps at the end of every bit period.
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            cnt <= '0;    // A restart lines the period up with the start bit.
        end else if (cnt == LAST_CNT) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // High in the last cycle of a period, so the engine moves on the wrap edge.
    assign tick = (cnt == LAST_CNT) && !restart;

endmodule

//--- serial_send/serial_send.sv
`timescale 1ns/1ns

module serial_send
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t rd_data,
    input  logic  rd_avail,
    output logic  rd_take,
    output logic  txd,
    output logic  busy
);

    localparam bit_idx_t LAST_BIT = 4'd9;    // Index of the stop bit.

    tx_state_e state;
    tx_state_e state_n;

    frame_t   frame_q;
    frame_t   frame_n;
    bit_idx_t bit_idx_q;
    bit_idx_t bit_idx_n;
    byte_t    data_q;
    byte_t    data_n;

    logic bit_restart;
    logic bit_tick;

    baud_gen u_baud_gen (
        .clk     (clk),
        .rst     (rst),
        .restart (bit_restart),
        .tick    (bit_tick)
    );

    always_comb begin
        state_n     = state;
        frame_n     = frame_q;
        bit_idx_n   = bit_idx_q;
        data_n      = data_q;
        rd_take     = 1'b0;
        bit_restart = 1'b0;

        case (state)
            TX_IDLE: begin
                if (rd_avail) begin
                    rd_take = 1'b1;      // Pops the head byte on this edge.
                    data_n  = rd_data;
                    state_n = TX_LOAD;
                end
            end

            TX_LOAD: begin
                frame_n     = {1'b1, data_q, 1'b0};    // Stop, data LSB first, start.
                bit_idx_n   = '0;
                bit_restart = 1'b1;    // Bit period starts with the start bit.
                state_n     = TX_SEND;
            end

            TX_SEND: begin
                if (bit_tick) begin
                    // Ones fill in from the top so the line is high once the frame is out.
                    frame_n = {1'b1, frame_q[9:1]};
                    if (bit_idx_q == LAST_BIT) begin
                        state_n = TX_IDLE;
                    end else begin
                        bit_idx_n = bit_idx_q + 1'b1;
                    end
                end
            end

            default: begin
                state_n = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_IDLE;
            frame_q   <= '1;    // Idle line is high.
            bit_idx_q <= '0;
        end else begin
            state     <= state_n;
            frame_q   <= frame_n;
            bit_idx_q <= bit_idx_n;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_n;
    end

    assign txd  = frame_q[0];
    assign busy = (state != TX_IDLE);    // Covers the load cycle and all ten bits.

endmodule

//--- verilog/uart_tx_top.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_tx_top
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_data,
    input  logic  tx_we,
    output logic  tx_full,
    output logic  txd,
    output logic  busy
);

    byte_t rd_data;
    logic  rd_avail;
    logic  rd_take;

    // Host bytes wait here until the engine is free.
    tx_fifo #(
        .DEPTH (`UART_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (tx_data),
        .wr_en    (tx_we),
        .full     (tx_full),
        .rd_data  (rd_data),
        .rd_avail (rd_avail),
        .rd_take  (rd_take)
    );

    // Takes one byte at a time and drives the line.
    serial_send u_serial_send (
        .clk      (clk),
        .rst      (rst),
        .rd_data  (rd_data),
        .rd_avail (rd_avail),
        .rd_take  (rd_take),
        .txd      (txd),
        .busy     (busy)
    );

endmodule

//--- sim/tb_uart_tx.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module tb_uart_tx
    import uart_pkg::*;
();

    localparam int CPB         = `UART_CLKS_PER_BIT;
    localparam int FIFO_DEPTH  = `UART_FIFO_DEPTH;
    localparam int FRAME_CLKS  = 10 * CPB + 2;    // Ten bits plus the take and load cycles.
    localparam int MON_TIMEOUT = 2 * FRAME_CLKS;

    logic  clk;
    logic  rst;
    byte_t tx_data;
    logic  tx_we;
    logic  tx_full;
    logic  txd;
    logic  busy;

    byte_t expected[$];    // Bytes the FIFO accepted, oldest first.

    uart_tx_top DUT (
        .clk     (clk),
        .rst     (rst),
        .tx_data (tx_data),
        .tx_we   (tx_we),
        .tx_full (tx_full),
        .txd     (txd),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Inputs change one ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input byte_t b, output logic accepted);
        tx_data  = b;
        tx_we    = 1'b1;
        accepted = !tx_full;    // This is the value the FIFO sees at the write edge.
        if (accepted) begin
            expected.push_back(b);
        end
        step();
        tx_we = 1'b0;
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        while (tx_full) begin
            step();
            n++;
            assert (n < MON_TIMEOUT) else fail_now("timeout waiting for tx_full to fall");
        end
    endtask

    task automatic wait_drained();
        int n;
        int limit;
        n     = 0;
        limit = (expected.size() + 2) * FRAME_CLKS;
        while (expected.size() != 0 || busy) begin
            step();
            n++;
            assert (n < limit) else fail_now("timeout waiting for all bytes to be sent");
        end
    endtask

    // Samples the line at every falling clock edge, where txd is stable.
    task automatic monitor_line();
        logic  prev;
        int    idle;
        int    high_run;
        byte_t got;
        byte_t exp;
        prev     = 1'b1;
        idle     = 0;
        high_run = CPB;
        forever begin
            @(negedge clk);
            if (prev === 1'b1 && txd === 1'b0) begin
                assert (expected.size() != 0) else fail_now("start bit seen with no byte pending");
                assert (high_run >= CPB / 2)
                    else fail_now("line was high for less than one bit between frames");
                repeat (CPB / 2) @(negedge clk);    // Middle of the start bit.
                assert (txd === 1'b0) else fail_now("start bit did not stay low to its center");
                assert (busy === 1'b1) else fail_now("busy was low during a frame");
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge clk);
                    got[i] = txd;
                    assert (busy === 1'b1) else fail_now("busy was low during a frame");
                end
                repeat (CPB) @(negedge clk);
                assert (txd === 1'b1) else fail_now("stop bit was not high");
                exp = expected.pop_front();
                assert (got === exp)
                    else fail_now($sformatf("mismatch txd_byte expected %h actual %h", exp, got));
                prev     = txd;
                idle     = 0;
                high_run = 0;
            end else begin
                prev = txd;
                if (txd === 1'b1) begin
                    high_run++;
                end
                if (expected.size() != 0) begin
                    idle++;
                    assert (idle < MON_TIMEOUT) else fail_now("timeout waiting for a start bit");
                end else begin
                    idle = 0;
                end
            end
        end
    endtask

    initial begin : main_flow
        logic  ok;
        int    n;
        int    dropped;
        int    offered;
        byte_t b;

        void'($urandom(32'hfb64));
        rst     = 1'b1;
        tx_we   = 1'b0;
        tx_data = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        fork
            monitor_line();
        join_none

        // Idle line after reset.
        repeat (20) begin
            step();
            assert (txd === 1'b1)
                else fail_now($sformatf("mismatch txd expected %h actual %h", 1'b1, txd));
            assert (busy === 1'b0)
                else fail_now($sformatf("mismatch busy expected %h actual %h", 1'b0, busy));
            assert (tx_full === 1'b0)
                else fail_now($sformatf("mismatch tx_full expected %h actual %h", 1'b0, tx_full));
        end

        // One byte.
        write_byte(8'hA5, ok);
        assert (ok) else fail_now("write refused while the FIFO was empty");
        n = 0;
        while (!busy) begin
            step();
            n++;
            assert (n < 10) else fail_now("timeout waiting for busy to rise");
        end
        wait_drained();

        // The engine takes the first byte, so depth plus one fits.
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            write_byte(byte_t'(8'h10 + i), ok);
            assert (ok) else fail_now("tx_full rose during a burst that should fit");
        end
        wait_drained();

        // Keep writing while the engine is busy.
        dropped = 0;
        offered = 3 * FIFO_DEPTH;
        for (int i = 0; i < offered; i++) begin
            write_byte(byte_t'(8'h80 + i), ok);
            if (!ok) begin
                dropped++;
            end
        end
        assert (dropped > 0) else fail_now("tx_full never rose during the overflow burst");
        // One byte goes to the engine and a full FIFO holds the rest.
        assert (offered - dropped == FIFO_DEPTH + 1)
            else fail_now($sformatf("mismatch accepted expected %h actual %h",
                                    FIFO_DEPTH + 1, offered - dropped));
        wait_drained();

        // Random bytes with random gaps.
        repeat (200) begin
            wait_not_full();
            b = byte_t'($urandom_range(255, 0));
            write_byte(b, ok);
            repeat ($urandom_range(40, 0)) step();
        end
        wait_drained();
        assert (tx_full === 1'b0)
            else fail_now($sformatf("mismatch tx_full expected %h actual %h", 1'b0, tx_full));

        $display("Test OK");
        $finish;
    end

endmodule

//--- sim.f
+incdir+common
common/uart_pkg.sv
verilog/tx_fifo.sv
serial_send/baud_gen.sv
serial_send/serial_send.sv
verilog/uart_tx_top.sv
sim/tb_uart_tx.sv

//--- Bender.yml
package:
  name: uart_tx

export_include_dirs:
  - common

sources:
  - target: any(rtl, simulation)
    include_dirs:
      - common
    files:
      - common/uart_pkg.sv
      - verilog/tx_fifo.sv
      - serial_send/baud_gen.sv
      - serial_send/serial_send.sv
      - verilog/uart_tx_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_uart_tx.sv
